/* project.f */
src/nabp_pkg.sv
src/projection_fir.sv
src/filtered_ram_bank.sv
src/filtered_ram_swap_control.sv
src/nabp_filtered_ram.sv
tests/tb_nabp_filtered_ram.sv

/* Makefile */
# tool, flags, top module and sources
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_nabp_filtered_ram
FILELIST  := project.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***

SHELL := /bin/bash

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# a crash or a logged failure both fail the target
run: compile
	set -o pipefail; ./$(SIM_BIN) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@echo "no failure found in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_nabp_filtered_ram.sv */
`timescale 1ns/10ps

module tb_nabp_filtered_ram;

    import nabp_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // run length and limits
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int n_angles = 12;
    localparam int max_host_delay = 6;
    localparam int max_cons_delay = 80;
    localparam int drain_cycles = 40;
    // kick edge to last write edge of one bank fill
    localparam int fill_cycles = k_proj_length + k_fill_delay + 1;
    localparam int timeout_cycles =
        n_angles * (fill_cycles + max_host_delay + 2 * max_cons_delay + 8) + drain_cycles + 200;
    localparam logic [31:0] seed = 32'h610eb4fe;

    // consumer phases
    localparam int c_release = 0;
    localparam int c_next = 1;
    localparam int c_drain = 2;

    logic                                clk;
    logic                                reset_n;
    logic                                hs_next_angle;
    logic                                hs_next_angle_ack;
    host_angle_t                         hs_reply;
    logic [k_s_length-1:0]               hs_s;
    logic signed [k_sample_length-1:0]   hs_sample;
    logic                                pr_next_angle;
    logic                                pr_prev_angle_release;
    logic                                pr_next_angle_ack;
    logic                                pr_prev_angle_release_ack;
    logic [k_angle_length-1:0]           pr_angle;
    logic                                pr_has_next_angle;
    pr_addr_t                            pr_addr;
    pr_data_t                            pr_data;

    // ~~~~~~~~~~~~~~~~~~~~
    // model state
    // ~~~~~~~~~~~~~~~~~~~~

    // host projection store and reference filtered values, by reply order
    int                        samples [n_angles][k_proj_length];
    int                        filtered [n_angles][k_proj_length];
    logic [k_angle_length-1:0] reply_angle [n_angles];
    logic                      reply_has_next [n_angles];

    int error_count;
    int check_count;
    int cyc;

    // host side: next reply, ack delay, angle served by the sample RAM
    int host_idx;
    int host_wait;
    int fill_idx;
    // angle held in the standby bank and the cycle its fill was acked
    int standby_idx;
    int standby_ack_cyc;

    // angle seen by each processing port, -1 while the bank is stale
    int w0;
    int w1;
    int cons_phase;
    int cons_wait;
    int drain_count;
    bit done;

    // read data due next cycle
    bit                           exp_valid;
    logic [k_filtered_length-1:0] exp0;
    logic [k_filtered_length-1:0] exp1;
    // angle handed out on the last release
    bit                           angle_pending;
    logic [k_angle_length-1:0]    exp_angle;
    logic                         exp_has_next;

    // inputs for the next cycle
    logic                              nxt_ack;
    host_angle_t                       nxt_reply;
    logic signed [k_sample_length-1:0] nxt_sample;
    logic                              nxt_next;
    logic                              nxt_release;
    pr_addr_t                          nxt_addr;

    nabp_filtered_ram u_nabp_filtered_ram
    (
        .clk                       (clk),
        .reset_n                   (reset_n),
        .hs_next_angle             (hs_next_angle),
        .hs_next_angle_ack         (hs_next_angle_ack),
        .hs_reply                  (hs_reply),
        .hs_s                      (hs_s),
        .hs_sample                 (hs_sample),
        .pr_next_angle             (pr_next_angle),
        .pr_prev_angle_release     (pr_prev_angle_release),
        .pr_next_angle_ack         (pr_next_angle_ack),
        .pr_prev_angle_release_ack (pr_prev_angle_release_ack),
        .pr_angle                  (pr_angle),
        .pr_has_next_angle         (pr_has_next_angle),
        .pr_addr                   (pr_addr),
        .pr_data                   (pr_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic expect_equal(string name, logic [31:0] actual, logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED %s: got %h, expected %h at cycle %0d", name, actual, expected, cyc);
        end
    endtask

    task automatic report_problem(string what);
        error_count++;
        $display("error at cycle %0d: %s", cyc, what);
    endtask

    // 2 x[s] - x[s-1] - x[s+1], zero outside the projection
    function automatic int ramp_filter(int k, int s);
        int left;
        int right;
        left = (s > 0) ? samples[k][s-1] : 0;
        right = (s < k_proj_length - 1) ? samples[k][s+1] : 0;
        return 2 * samples[k][s] - left - right;
    endfunction

    function automatic logic [k_s_length-1:0] pick_index();
        int r;
        r = $urandom_range(0, 7);
        // edge detectors have only one real neighbour
        if (r == 0)
            return '0;
        if (r == 1)
            return k_s_length'(k_proj_length - 1);
        return k_s_length'($urandom_range(0, k_proj_length - 1));
    endfunction

    function automatic pr_addr_t random_addr();
        pr_addr_t a;
        a.s0 = pick_index();
        a.s1 = pick_index();
        return a;
    endfunction

    // mostly quick, now and then slow enough to outlast a fill
    function automatic int pick_consumer_delay();
        if ($urandom_range(0, 3) == 0)
            return $urandom_range(0, max_cons_delay);
        return $urandom_range(0, 8);
    endfunction

    task automatic build_stimulus();
        for (int k = 0; k < n_angles; k++)
        begin
            reply_angle[k] = k_angle_length'($urandom);
            reply_has_next[k] = (k != n_angles - 1);
            for (int s = 0; s < k_proj_length; s++)
                samples[k][s] = int'($urandom_range(0, 4095)) - 2048;
        end
        // full scale alternation, filtered values near both 14 bit limits
        for (int s = 0; s < k_proj_length; s++)
            samples[1][s] = (s % 2 == 0) ? -2048 : 2047;
        for (int k = 0; k < n_angles; k++)
            for (int s = 0; s < k_proj_length; s++)
                filtered[k][s] = ramp_filter(k, s);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // per cycle model, runs at the falling edge
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic check_read_data();
        // data for last cycle's address, roles of last cycle
        if (exp_valid)
        begin
            expect_equal("pr_data.val0", 32'($unsigned(pr_data.val0)), 32'(exp0));
            expect_equal("pr_data.val1", 32'($unsigned(pr_data.val1)), 32'(exp1));
        end
        if (angle_pending)
        begin
            expect_equal("pr_angle", 32'(pr_angle), 32'(exp_angle));
            expect_equal("pr_has_next_angle", 32'(pr_has_next_angle), 32'(exp_has_next));
            angle_pending = 1'b0;
        end
        exp_valid = (w0 >= 0);
        if (exp_valid)
        begin
            exp0 = k_filtered_length'(filtered[w0][pr_addr.s0]);
            exp1 = k_filtered_length'(filtered[w1][pr_addr.s1]);
        end
    endtask

    task automatic follow_handshakes();
        // release hands the standby angle to both ports
        if (pr_prev_angle_release_ack)
        begin
            if (cons_phase != c_release || !pr_prev_angle_release)
                report_problem("pr_prev_angle_release_ack without a pending release");
            else if (standby_idx < 0)
                report_problem("release acknowledged with no filled angle");
            else
            begin
                w0 = standby_idx;
                w1 = standby_idx;
                angle_pending = 1'b1;
                exp_angle = reply_angle[standby_idx];
                exp_has_next = reply_has_next[standby_idx];
            end
        end
        // next angle moves port 1 only
        if (pr_next_angle_ack)
        begin
            if (cons_phase != c_next || !pr_next_angle)
                report_problem("pr_next_angle_ack without a pending request");
            else if (cyc - standby_ack_cyc <= fill_cycles)
                report_problem("pr_next_angle_ack before the standby bank could be filled");
            else
                w1 = standby_idx;
        end
        // host reply starts the next fill
        if (hs_next_angle_ack)
        begin
            if (!hs_next_angle)
                report_problem("hs_next_angle dropped while the host was answering");
            standby_idx = host_idx;
            standby_ack_cyc = cyc;
            fill_idx = host_idx;
            host_idx++;
        end
    endtask

    task automatic plan_host();
        // sample RAM answers one cycle later
        nxt_sample = (fill_idx < 0) ? '0 : k_sample_length'(samples[fill_idx][hs_s]);
        // reply bus carries junk outside the ack cycle
        nxt_ack = 1'b0;
        nxt_reply.angle = k_angle_length'($urandom);
        nxt_reply.has_next = 1'($urandom);
        if (hs_next_angle_ack)
            host_wait = $urandom_range(0, max_host_delay);
        else if (hs_next_angle && host_idx < n_angles)
        begin
            if (host_wait == 0)
            begin
                nxt_ack = 1'b1;
                nxt_reply.angle = reply_angle[host_idx];
                nxt_reply.has_next = reply_has_next[host_idx];
            end
            else
                host_wait--;
        end
        else
            host_wait = $urandom_range(0, max_host_delay);
    endtask

    task automatic plan_consumer();
        nxt_addr = random_addr();
        case (cons_phase)
            c_release:
                if (pr_prev_angle_release_ack)
                begin
                    nxt_release = 1'b0;
                    cons_wait = pick_consumer_delay();
                    cons_phase = exp_has_next ? c_next : c_drain;
                end
                else if (!pr_prev_angle_release)
                begin
                    if (cons_wait == 0)
                        nxt_release = 1'b1;
                    else
                        cons_wait--;
                end
            c_next:
                if (pr_next_angle_ack)
                begin
                    nxt_next = 1'b0;
                    cons_wait = pick_consumer_delay();
                    cons_phase = c_release;
                end
                else if (!pr_next_angle)
                begin
                    if (cons_wait == 0)
                        nxt_next = 1'b1;
                    else
                        cons_wait--;
                end
            default:
            begin
                // nothing left to fill, both requests must go unanswered
                nxt_next = 1'b1;
                nxt_release = 1'b1;
                drain_count++;
                if (drain_count == drain_cycles)
                begin
                    expect_equal("hs_next_angle", 32'(hs_next_angle), 32'd1);
                    done = 1'b1;
                end
            end
        endcase
    endtask

    task automatic apply_inputs();
        hs_next_angle_ack = nxt_ack;
        hs_reply = nxt_reply;
        hs_sample = nxt_sample;
        pr_next_angle = nxt_next;
        pr_prev_angle_release = nxt_release;
        pr_addr = nxt_addr;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        void'($urandom(seed));
        reset_n = 1'b0;
        hs_next_angle_ack = 1'b0;
        hs_reply = '0;
        hs_sample = '0;
        pr_next_angle = 1'b0;
        pr_prev_angle_release = 1'b0;
        pr_addr = '0;
        nxt_ack = 1'b0;
        nxt_reply = '0;
        nxt_sample = '0;
        nxt_next = 1'b0;
        nxt_release = 1'b0;
        nxt_addr = '0;
        error_count = 0;
        check_count = 0;
        cyc = 0;
        host_idx = 0;
        host_wait = $urandom_range(0, max_host_delay);
        fill_idx = -1;
        standby_idx = -1;
        standby_ack_cyc = -1000;
        w0 = -1;
        w1 = -1;
        cons_phase = c_release;
        cons_wait = pick_consumer_delay();
        drain_count = 0;
        done = 1'b0;
        exp_valid = 1'b0;
        angle_pending = 1'b0;
        build_stimulus();

        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(negedge clk);

        // idle state straight out of reset
        expect_equal("hs_next_angle", 32'(hs_next_angle), 32'd1);
        expect_equal("pr_next_angle_ack", 32'(pr_next_angle_ack), 32'd0);
        expect_equal("pr_prev_angle_release_ack", 32'(pr_prev_angle_release_ack), 32'd0);
        expect_equal("pr_has_next_angle", 32'(pr_has_next_angle), 32'd1);

        while (!done)
        begin
            check_read_data();
            follow_handshakes();
            plan_host();
            plan_consumer();
            @(posedge clk);
            #1;
            apply_inputs();
            @(negedge clk);
            cyc++;
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // ends a stuck run
    initial
    begin : watchdog
        int cycles_run;
        cycles_run = 0;
        while (cycles_run < timeout_cycles)
        begin
            @(posedge clk);
            cycles_run++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* src/nabp_filtered_ram.sv */
`timescale 1ns/10ps

module nabp_filtered_ram
(
    input  logic                                        clk,
    input  logic                                        reset_n,
    // host angle handshake
    output logic                                        hs_next_angle,
    input  logic                                        hs_next_angle_ack,
    input  nabp_pkg::host_angle_t                       hs_reply,
    // host sample RAM read
    output logic [nabp_pkg::k_s_length-1:0]             hs_s,
    input  logic signed [nabp_pkg::k_sample_length-1:0] hs_sample,
    // processing handshake
    input  logic                                        pr_next_angle,
    input  logic                                        pr_prev_angle_release,
    output logic                                        pr_next_angle_ack,
    output logic                                        pr_prev_angle_release_ack,
    output logic [nabp_pkg::k_angle_length-1:0]         pr_angle,
    output logic                                        pr_has_next_angle,
    // processing reads
    input  nabp_pkg::pr_addr_t                          pr_addr,
    output nabp_pkg::pr_data_t                          pr_data
);

    import nabp_pkg::*;

    // filter restart and filtered stream into the banks
    logic                                fill_start;
    logic signed [k_filtered_length-1:0] fir_val;

    // ramp filter sits between the host RAM and the banks
    projection_fir u_projection_fir
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .fill_start (fill_start),
        .hs_sample  (hs_sample),
        .fir_val    (fir_val)
    );

    // ping-pong banks, angle FSM and read routing
    filtered_ram_swap_control u_filtered_ram_swap_control
    (
        .clk                       (clk),
        .reset_n                   (reset_n),
        .hs_next_angle             (hs_next_angle),
        .hs_next_angle_ack         (hs_next_angle_ack),
        .hs_reply                  (hs_reply),
        .fir_val                   (fir_val),
        .hs_s                      (hs_s),
        .fill_start                (fill_start),
        .pr_next_angle             (pr_next_angle),
        .pr_prev_angle_release     (pr_prev_angle_release),
        .pr_next_angle_ack         (pr_next_angle_ack),
        .pr_prev_angle_release_ack (pr_prev_angle_release_ack),
        .pr_angle                  (pr_angle),
        .pr_has_next_angle         (pr_has_next_angle),
        .pr_addr                   (pr_addr),
        .pr_data                   (pr_data)
    );

endmodule

/* src/filtered_ram_swap_control.sv */
`timescale 1ns/10ps

module filtered_ram_swap_control
(
    input  logic                                          clk,
    input  logic                                          reset_n,
    // host angle handshake
    output logic                                          hs_next_angle,
    input  logic                                          hs_next_angle_ack,
    input  nabp_pkg::host_angle_t                         hs_reply,
    // filter side
    input  logic signed [nabp_pkg::k_filtered_length-1:0] fir_val,
    output logic [nabp_pkg::k_s_length-1:0]               hs_s,
    output logic                                          fill_start,
    // processing handshake
    input  logic                                          pr_next_angle,
    input  logic                                          pr_prev_angle_release,
    output logic                                          pr_next_angle_ack,
    output logic                                          pr_prev_angle_release_ack,
    output logic [nabp_pkg::k_angle_length-1:0]           pr_angle,
    output logic                                          pr_has_next_angle,
    // processing reads
    input  nabp_pkg::pr_addr_t                            pr_addr,
    output nabp_pkg::pr_data_t                            pr_data
);

    import nabp_pkg::*;

    // bank roles by sw_sel
    //   sw_sel 0 means bank_a works and bank_b fills
    //   sw_sel 1 means bank_a fills and bank_b works
    swap_state_t state;
    swap_state_t next_state;
    logic        sw_sel;

    // stored host reply belongs to the bank being filled
    host_angle_t reply_q;
    logic        avail;

    logic swap_prev;
    logic swap_cond;
    logic swap;
    logic fill_kick;
    logic fill_busy;
    logic fill_done;
    logic release_grant;

    // per bank wiring
    logic                  kick_a;
    logic                  kick_b;
    logic                  done_a;
    logic                  done_b;
    logic [k_s_length-1:0] hs_s_a;
    logic [k_s_length-1:0] hs_s_b;
    pr_data_t              data_a;
    pr_data_t              data_b;

    // ~~~~~~~~~~~~~~~~~~~~
    // handshakes
    // ~~~~~~~~~~~~~~~~~~~~

    // host still has an angle to hand out
    assign avail = reply_q.has_next;

    // release only once the standby bank holds a complete angle
    assign release_grant = pr_prev_angle_release && !fill_busy &&
                           (state == fill_s || state == diverged_work_s);

    // request on reset exit, then on every granted release while angles remain
    assign hs_next_angle = (state == ready_s) || (release_grant && avail);

    // host ack drives the swap, or the release alone when nothing is left
    assign swap_cond = avail ? hs_next_angle_ack : release_grant;
    assign swap = swap_cond && !swap_prev;

    // the old working bank is refilled with the new angle
    assign fill_kick = swap && avail;
    assign fill_start = fill_kick;

    assign pr_prev_angle_release_ack = (state != ready_s) && pr_prev_angle_release && swap;
    assign pr_next_angle_ack = pr_next_angle && !fill_busy && (state == fill_and_work_s);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            swap_prev <= 1'b0;
        else
            swap_prev <= swap_cond;
    end

    // fill in flight from kick to last write
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            fill_busy <= 1'b0;
        else if (fill_kick)
            fill_busy <= 1'b1;
        else if (fill_done)
            fill_busy <= 1'b0;
    end

    // latch the reply on ack and re-arm availability once drained
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            reply_q <= '{angle: '0, has_next: 1'b1};
        else if (hs_next_angle_ack)
            reply_q <= hs_reply;
        else if (state == work_s && next_state == ready_s)
            reply_q.has_next <= 1'b1;
    end

    // hand the filled bank's angle to processing on release
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            pr_has_next_angle <= 1'b1;
        else if (pr_prev_angle_release_ack)
        begin
            pr_angle <= reply_q.angle;
            pr_has_next_angle <= reply_q.has_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // angle FSM
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ready_s;
            sw_sel <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (swap)
                sw_sel <= !sw_sel;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (hs_next_angle_ack)
                    next_state = fill_s;
            // working bank stays stale until the first fill and release
            fill_s:
                if (swap)
                    next_state = avail ? fill_and_work_s : work_s;
            fill_and_work_s:
                if (pr_next_angle_ack)
                    next_state = diverged_work_s;
            diverged_work_s:
                if (pr_prev_angle_release_ack)
                    next_state = avail ? fill_and_work_s : work_s;
            // last angle sits in the working bank and no fill may be left in flight
            work_s:
                if (!fill_busy)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // banks and routing
    // ~~~~~~~~~~~~~~~~~~~~

    // kick goes to the bank that becomes the filling one after the toggle
    assign kick_a = fill_kick && !sw_sel;
    assign kick_b = fill_kick && sw_sel;
    assign fill_done = sw_sel ? done_a : done_b;
    assign hs_s = sw_sel ? hs_s_a : hs_s_b;

    filtered_ram_bank bank_a
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .fill_kick (kick_a),
        .fir_val   (fir_val),
        .hs_s      (hs_s_a),
        .fill_done (done_a),
        .pr_addr   (pr_addr),
        .pr_data   (data_a)
    );

    filtered_ram_bank bank_b
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .fill_kick (kick_b),
        .fir_val   (fir_val),
        .hs_s      (hs_s_b),
        .fill_done (done_b),
        .pr_addr   (pr_addr),
        .pr_data   (data_b)
    );

    // routing follows the cycle the address was issued
    logic sel_q;
    logic div_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sel_q <= 1'b0;
            div_q <= 1'b0;
        end
        else
        begin
            sel_q <= sw_sel;
            div_q <= (state == diverged_work_s);
        end
    end

    // when diverged port 0 stays on the old angle and port 1 moves to the new one
    assign pr_data.val0 = sel_q ? data_b.val0 : data_a.val0;
    assign pr_data.val1 = (sel_q ^ div_q) ? data_b.val1 : data_a.val1;

    a_acks_exclusive: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(pr_next_angle_ack && pr_prev_angle_release_ack)
    );

    // bank roles only flip on the first angle out of ready_s or on an acked release
    a_sel_on_swap: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(state == ready_s || pr_prev_angle_release_ack) |=> $stable(sw_sel)
    );

endmodule

/* src/filtered_ram_bank.sv */
`timescale 1ns/10ps

module filtered_ram_bank
(
    input  logic                                          clk,
    input  logic                                          reset_n,
    input  logic                                          fill_kick,
    input  logic signed [nabp_pkg::k_filtered_length-1:0] fir_val,
    // read index towards the host sample RAM
    output logic [nabp_pkg::k_s_length-1:0]               hs_s,
    // high on the cycle the last filtered value is written
    output logic                                          fill_done,
    input  nabp_pkg::pr_addr_t                            pr_addr,
    output nabp_pkg::pr_data_t                            pr_data
);

    import nabp_pkg::*;

    localparam int idx_width = k_s_length + 1;
    // one extra step since filtered[s] needs x[s+1]
    localparam int wr_depth = k_fill_delay + 1;
    localparam logic [idx_width-1:0] flush_idx = idx_width'(k_proj_length);
    localparam logic [k_s_length-1:0] last_idx = k_s_length'(k_proj_length - 1);

    // ~~~~~~~~~~~~~~~~~~~~
    // fill sequencer
    // ~~~~~~~~~~~~~~~~~~~~

    logic                 filling;
    logic [idx_width-1:0] rd_idx;
    // index in range, a real sample request rather than the flush
    logic                 rd_live;

    // counts 0..k_proj_length-1 then one flush step
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            filling <= 1'b0;
            rd_idx <= '0;
        end
        else if (fill_kick)
        begin
            filling <= 1'b1;
            rd_idx <= '0;
        end
        else if (filling)
        begin
            if (rd_idx == flush_idx)
                filling <= 1'b0;
            else
                rd_idx <= rd_idx + 1'b1;
        end
    end

    assign rd_live = filling && (rd_idx < flush_idx);
    // flush index wraps to 0, the FIR masks that sample
    assign hs_s = filling ? rd_idx[k_s_length-1:0] : '0;

    // ~~~~~~~~~~~~~~~~~~~~
    // write address delay
    // ~~~~~~~~~~~~~~~~~~~~

    logic [wr_depth-1:0]   wr_valid_pipe;
    logic [k_s_length-1:0] wr_idx_pipe [wr_depth];
    logic                  wr_en;
    logic [k_s_length-1:0] wr_addr;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            wr_valid_pipe <= '0;
        else
            wr_valid_pipe <= {wr_valid_pipe[wr_depth-2:0], rd_live};
    end

    always_ff @(posedge clk)
    begin
        wr_idx_pipe[0] <= rd_idx[k_s_length-1:0];
        for (int i = 1; i < wr_depth; i++)
            wr_idx_pipe[i] <= wr_idx_pipe[i-1];
    end

    // index now lines up with fir_val
    assign wr_en = wr_valid_pipe[wr_depth-1];
    assign wr_addr = wr_idx_pipe[wr_depth-1];
    assign fill_done = wr_en && (wr_addr == last_idx);

    // ~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~

    logic signed [k_filtered_length-1:0] mem [k_proj_length];

    // one write port from the filter, two registered read ports
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= fir_val;
        pr_data.val0 <= mem[pr_addr.s0];
        pr_data.val1 <= mem[pr_addr.s1];
    end

    // a kick mid-fill would corrupt the write sequence in flight
    a_no_kick_while_busy: assert property (
        @(posedge clk) disable iff (!reset_n)
        fill_kick |-> !(filling || (|wr_valid_pipe))
    );

endmodule

/* src/projection_fir.sv */
`timescale 1ns/10ps

module projection_fir
(
    input  logic                                          clk,
    input  logic                                          reset_n,
    // one cycle pulse when a bank fill is kicked
    input  logic                                          fill_start,
    input  logic signed [nabp_pkg::k_sample_length-1:0]   hs_sample,
    output logic signed [nabp_pkg::k_filtered_length-1:0] fir_val
);

    import nabp_pkg::*;

    localparam int pos_width = k_s_length + 1;
    // sample for s = 0 lands k_host_latency cycles after the first index
    localparam logic [pos_width-1:0] first_pos = pos_width'(k_host_latency);
    localparam logic [pos_width-1:0] last_pos = pos_width'(k_host_latency + k_proj_length - 1);
    localparam logic [pos_width-1:0] end_pos = pos_width'(k_host_latency + k_proj_length);

    // position of the incoming sample within the current fill
    logic [pos_width-1:0] pos;
    // masked input, two deep history x[s] and x[s-1]
    logic signed [k_sample_length-1:0] x_in;
    logic signed [k_sample_length-1:0] h0;
    logic signed [k_sample_length-1:0] h1;
    // first pipeline stage, centre and summed side products
    logic signed [k_filtered_length-1:0] centre_term;
    logic signed [k_filtered_length-1:0] side_term;

    // samples outside 0..k_proj_length-1 count as zero, covers the flush step
    assign x_in = (pos >= first_pos && pos <= last_pos) ? hs_sample : '0;

    // sample position counter, parks at end_pos between fills
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            pos <= end_pos;
        else if (fill_start)
            pos <= '0;
        else if (pos != end_pos)
            pos <= pos + 1'b1;
    end

    // history starts from zero neighbours for every angle
    always_ff @(posedge clk)
    begin
        if (!reset_n || fill_start)
        begin
            h0 <= '0;
            h1 <= '0;
        end
        else
        begin
            h0 <= x_in;
            h1 <= h0;
        end
    end

    // stage 1: x_in is x[s+1], h0 is x[s], h1 is x[s-1]
    always_ff @(posedge clk)
    begin
        centre_term <= k_tap_centre * k_filtered_length'(h0);
        side_term <= k_tap_side * (k_filtered_length'(h1) + k_filtered_length'(x_in));
    end

    // stage 2: tap sum, filtered[s]
    always_ff @(posedge clk)
    begin
        fir_val <= centre_term + side_term;
    end

endmodule

/* src/nabp_pkg.sv */
package nabp_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~

    // angle index into the host projection store
    localparam int k_angle_length = 8;
    // detector index s, one projection is k_proj_length samples
    localparam int k_s_length = 6;
    localparam int k_proj_length = 64;
    // raw host sample, signed
    localparam int k_sample_length = 12;
    // filtered value, worst case |2x| + |x| + |x| fits without saturation
    localparam int k_filtered_length = 14;

    // ~~~~~~~~~~~~~~~~~~~~
    // ramp filter and latencies
    // ~~~~~~~~~~~~~~~~~~~~

    // centred three tap ramp approximation: -1, 2, -1
    localparam logic signed [k_filtered_length-1:0] k_tap_side = -14'sd1;
    localparam logic signed [k_filtered_length-1:0] k_tap_centre = 14'sd2;

    // hs_s to hs_sample
    localparam int k_host_latency = 1;
    // sample in to fir_val out
    localparam int k_fir_latency = 2;
    // index to filtered value alignment used by the banks
    localparam int k_fill_delay = k_host_latency + k_fir_latency;

    // ~~~~~~~~~~~~~~~~~~~~
    // types
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        ready_s,
        fill_s,
        fill_and_work_s,
        diverged_work_s,
        work_s
    } swap_state_t;

    // host reply to an angle request, valid on the ack cycle
    typedef struct packed {
        logic [k_angle_length-1:0] angle;
        logic                      has_next;
    } host_angle_t;

    // read addresses of the two processing ports
    typedef struct packed {
        logic [k_s_length-1:0] s0;
        logic [k_s_length-1:0] s1;
    } pr_addr_t;

    typedef struct packed {
        logic signed [k_filtered_length-1:0] val0;
        logic signed [k_filtered_length-1:0] val1;
    } pr_data_t;

endpackage
